// File: mini_core_top.f
+incdir+hdl
+incdir+verification
hdl/mini_core_pkg.sv
hdl/axil_ram.sv
hdl/core_decode.sv
hdl/core_execute.sv
hdl/core_result.sv
hdl/mini_core_top.sv
verification/mini_core_tb.sv

// File: Makefile
TOP := mini_core_tb

all: run

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Simulation completed successfully"

obj_dir/V$(TOP): mini_core_top.f hdl/*.sv hdl/*.svh verification/*.sv verification/*.svh
	verilator --binary --timing -f mini_core_top.f --top-module $(TOP)

lint:
	verilator --lint-only -Wall --timing -f mini_core_top.f --top-module mini_core_top

clean:
	rm -rf obj_dir

.PHONY: all run lint clean

// File: verification/isa_model.svh
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// architectural state, registers zero after reset
logic [`DATA_WIDTH-1:0] model_regs [`REG_COUNT];
logic [`DATA_WIDTH-1:0] model_mem [PRELOAD_WORDS];

// one expected retire report, in program order
typedef struct packed {
   logic                    we;
   logic [3:0]              rd;
   logic [`DATA_WIDTH-1:0]  data;
   logic                    check_data;
   logic                    check_time;
   logic [31:0]             accept_cycle;
} retire_rec_t;

retire_rec_t expected[$];

// r0 reads zero whatever was written to it
function automatic logic [`DATA_WIDTH-1:0] reg_value(input logic [3:0] idx);
   return (idx == 4'd0) ? '0 : model_regs[idx];
endfunction

// run one accepted instruction against the model
task automatic execute_instr(input logic [31:0] word, input int when, input bit timed);
   logic [3:0] op;
   logic [3:0] rd;
   logic [31:0] a;
   logic [31:0] b;
   logic [31:0] simm;
   logic [31:0] addr;
   logic [31:0] result;
   logic writes;
   retire_rec_t rec;
   op = word[31:28];
   rd = word[27:24];
   a = reg_value(word[23:20]);
   b = reg_value(word[19:16]);
   simm = {{16{word[15]}}, word[15:0]};
   // byte address, stimulus keeps it inside the preloaded words
   addr = a + simm;
   result = '0;
   writes = 1'b1;
   case (op)
      OP_ADD: result = a + b;
      OP_SUB: result = a - b;
      OP_AND: result = a & b;
      OP_OR: result = a | b;
      OP_XOR: result = a ^ b;
      OP_ADDI: result = a + simm;
      OP_LUI: result = {word[15:0], 16'h0000};
      // word access, low two address bits dropped
      OP_LW: result = model_mem[addr[7:2]];
      OP_SW: begin
         model_mem[addr[7:2]] = b;
         writes = 1'b0;
      end
      OP_SB: begin
         // lane picked by the byte offset
         model_mem[addr[7:2]][8*addr[1:0] +: 8] = b[7:0];
         writes = 1'b0;
      end
      default: writes = 1'b0;
   endcase
   rec.we = writes && rd != 4'd0;
   rec.rd = rd;
   rec.data = result;
   rec.check_data = writes;
   rec.check_time = timed;
   rec.accept_cycle = 32'(when);
   if (writes && rd != 4'd0) begin
      model_regs[rd] = result;
   end
   expected.push_back(rec);
endtask

`endif

// File: verification/mini_core_tb.sv
`timescale 1ns/1ns
`include "mini_core_defs.svh"

module mini_core_tb;

   import mini_core_pkg::*;

   localparam int PRELOAD_WORDS = 64;
   localparam int NUM_INSTRS = 300;
   localparam int CYCLE_LIMIT = NUM_INSTRS * 12 + 500;

   logic clk = 1'b0;
   logic rst = 1'b1;
   logic [`DATA_WIDTH-1:0] instr = '0;
   logic instr_valid = 1'b0;
   logic instr_ready;
   logic retire_valid;
   logic retire_we;
   logic [`REG_IDX_WIDTH-1:0] retire_rd;
   logic [`DATA_WIDTH-1:0] retire_data;
   logic [`ADDR_WIDTH-1:0] debug_addr = '0;
   logic [`DATA_WIDTH-1:0] debug_data;
   logic [`ADDR_WIDTH-1:0] debug_wr_addr = '0;
   logic [`DATA_WIDTH-1:0] debug_wr_data = '0;
   logic debug_wr_en = 1'b0;

   int cycle = 0;
   int checks = 0;
   int errors = 0;
   int retired = 0;
   int err_mark = 0;
   logic [31:0] lcg_state = 32'd50826;

   `include "isa_model.svh"

   mini_core_top mini_core_top_inst (
      .clk(clk),
      .rst(rst),
      .instr(instr),
      .instr_valid(instr_valid),
      .instr_ready(instr_ready),
      .retire_valid(retire_valid),
      .retire_we(retire_we),
      .retire_rd(retire_rd),
      .retire_data(retire_data),
      .debug_addr(debug_addr),
      .debug_data(debug_data),
      .debug_wr_addr(debug_wr_addr),
      .debug_wr_data(debug_wr_data),
      .debug_wr_en(debug_wr_en)
   );

   // 4 ns clock
   always #2 clk = ~clk;

   // cycle count and run limit
   always @(posedge clk) begin
      cycle <= cycle + 1;
      if (cycle >= CYCLE_LIMIT) begin
         $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("Simulation failed");
         $finish;
      end
   end

   // upper half of the LCG state, low bits cycle too fast
   function automatic logic [15:0] next_random();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state[31:16];
   endfunction

   // valid high three times in four
   function automatic logic draw_valid();
      logic [15:0] r;
      r = next_random();
      return r[1:0] != 2'd0;
   endfunction

   function automatic logic [31:0] encode(input logic [3:0] op, input logic [3:0] rd,
                                          input logic [3:0] rs1, input logic [3:0] rs2,
                                          input logic [15:0] imm);
      return {op, rd, rs1, rs2, imm};
   endfunction

   function automatic logic [31:0] make_instr(input logic [3:0] prev_rd);
      logic [15:0] r;
      logic [3:0] op;
      logic [3:0] rs1;
      logic [3:0] rs2;
      logic [15:0] imm;
      logic [31:0] base;
      // 11 and 12 land on unused opcodes
      op = 4'(next_random() % 16'd13);
      r = next_random();
      rs1 = r[7:4];
      rs2 = r[11:8];
      imm = next_random();
      // one in four reads the previous destination
      if (r[13:12] == 2'd0) begin
         if (r[14]) begin
            rs1 = prev_rd;
         end else begin
            rs2 = prev_rd;
         end
      end
      if (op == OP_LW || op == OP_SW || op == OP_SB) begin
         // word 0..63 plus a random byte offset, relative to the model's rs1
         base = reg_value(rs1);
         imm = (next_random() % 16'd256) - base[15:0];
      end
      return {op, r[3:0], rs1, rs2, imm};
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Error: %s got 0x%08h expected 0x%08h at cycle %0d", name, got, exp, cycle);
      end
   endtask

   task automatic check_retire();
      retire_rec_t rec;
      if (expected.size() == 0) begin
         errors++;
         $display("retire seen at cycle %0d with no instruction outstanding", cycle);
      end else begin
         rec = expected.pop_front();
         retired++;
         check_value("retire_rd", 32'(retire_rd), 32'(rec.rd));
         check_value("retire_we", 32'(retire_we), 32'(rec.we));
         if (rec.check_data) begin
            check_value("retire_data", retire_data, rec.data);
         end
         // acceptance to retire_valid, idle core
         if (rec.check_time) begin
            check_value("retire latency", 32'(cycle) - rec.accept_cycle, 32'd3);
         end
      end
   endtask

   // retire outputs settle after the rising edge
   always @(negedge clk) begin
      if (!rst && retire_valid) begin
         check_retire();
      end
   end

   // one instruction, held until taken
   task automatic send_instr(input logic [31:0] word, input bit timed);
      @(negedge clk);
      instr = word;
      instr_valid = 1'b1;
      #1;
      while (!instr_ready) begin
         @(negedge clk);
         #1;
      end
      execute_instr(word, cycle, timed);
      @(negedge clk);
      instr_valid = 1'b0;
   endtask

   task automatic wait_drain();
      while (expected.size() != 0) begin
         @(negedge clk);
      end
      @(negedge clk);
   endtask

   task automatic report_test(input string name);
      $display("test %s done: %0d errors", name, errors - err_mark);
      err_mark = errors;
   endtask

   initial begin
      logic [31:0] cur;
      logic [3:0] prev_rd;
      logic pending;
      int issued;
      cur = '0;
      prev_rd = 4'd0;
      pending = 1'b0;
      issued = 0;
      for (int i = 0; i < `REG_COUNT; i++) begin
         model_regs[i] = '0;
      end

      // preload starts under reset and runs on into the idle core
      for (int i = 0; i < PRELOAD_WORDS; i++) begin
         @(negedge clk);
         // no instruction taken while rst is high
         if (i <= 4) begin
            check_value("instr_ready", 32'(instr_ready), 32'd0);
         end
         // five rising edges have passed with rst high
         if (i == 4) begin
            rst = 1'b0;
         end
         // first cycle out of reset
         if (i == 5) begin
            check_value("instr_ready", 32'(instr_ready), 32'd1);
         end
         if (i > 4) begin
            check_value("retire_valid", 32'(retire_valid), 32'd0);
         end
         model_mem[i] = {next_random(), next_random()};
         debug_wr_addr = `ADDR_WIDTH'(i);
         debug_wr_data = model_mem[i];
         debug_wr_en = 1'b1;
      end
      @(negedge clk);
      debug_wr_en = 1'b0;
      check_value("instr_ready", 32'(instr_ready), 32'd1);
      check_value("retire_valid", 32'(retire_valid), 32'd0);
      report_test("reset_state");

      // lone ADDI into an empty pipeline
      send_instr(encode(OP_ADDI, 4'd1, 4'd0, 4'd0, 16'h8123), 1'b1);
      wait_drain();
      report_test("alu_latency");

      // r0 write then reads of r0
      send_instr(encode(OP_ADDI, 4'd0, 4'd1, 4'd0, 16'h1234), 1'b0);
      send_instr(encode(OP_ADD, 4'd2, 4'd0, 4'd0, 16'h0000), 1'b0);
      send_instr(encode(OP_OR, 4'd3, 4'd1, 4'd0, 16'h0000), 1'b0);
      wait_drain();
      report_test("r0_write");

      // random stream, valid toggles while the host holds the word
      while (issued < NUM_INSTRS) begin
         @(negedge clk);
         if (!pending) begin
            cur = make_instr(prev_rd);
            pending = 1'b1;
            instr_valid = draw_valid();
         end else if (!instr_valid) begin
            instr_valid = draw_valid();
         end
         instr = cur;
         #1;
         if (instr_valid && instr_ready) begin
            execute_instr(cur, cycle, 1'b0);
            prev_rd = cur[27:24];
            pending = 1'b0;
            issued++;
         end
      end
      @(negedge clk);
      instr_valid = 1'b0;
      wait_drain();
      report_test("random_stream");

      // stores show up in the RAM image
      for (int i = 0; i < PRELOAD_WORDS; i++) begin
         @(negedge clk);
         debug_addr = `ADDR_WIDTH'(i);
         #1;
         check_value($sformatf("debug_data[%0d]", i), debug_data, model_mem[i]);
      end
      report_test("memory_image");

      $display("checks %0d, errors %0d, retired %0d", checks, errors, retired);
      if (errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

// File: hdl/mini_core_top.sv
`timescale 1ns/1ns
`include "mini_core_defs.svh"

module mini_core_top (
   input  logic                     clk,
   input  logic                     rst,
   input  logic [`DATA_WIDTH-1:0]   instr,
   input  logic                     instr_valid,
   output logic                     instr_ready,
   output logic                     retire_valid,
   output logic                     retire_we,
   output logic [`REG_IDX_WIDTH-1:0] retire_rd,
   output logic [`DATA_WIDTH-1:0]   retire_data,
   input  logic [`ADDR_WIDTH-1:0]   debug_addr,
   output logic [`DATA_WIDTH-1:0]   debug_data,
   input  logic [`ADDR_WIDTH-1:0]   debug_wr_addr,
   input  logic [`DATA_WIDTH-1:0]   debug_wr_data,
   input  logic                     debug_wr_en
);

   import mini_core_pkg::*;

   // decode to execute
   logic dec_valid;
   logic exe_ready;
   opcode_t dec_op;
   op_class_t dec_class;
   reg_idx_t dec_rd;
   logic [`DATA_WIDTH-1:0] dec_a;
   logic [`DATA_WIDTH-1:0] dec_b;
   logic [`DATA_WIDTH-1:0] dec_store_data;

   // execute to result
   logic res_valid;
   logic res_we;
   reg_idx_t res_rd;
   logic [`DATA_WIDTH-1:0] res_data;

   // register reads and scoreboard clear
   reg_idx_t rf_a_idx;
   reg_idx_t rf_b_idx;
   logic [`DATA_WIDTH-1:0] rf_a;
   logic [`DATA_WIDTH-1:0] rf_b;
   logic wb_valid;
   reg_idx_t wb_rd;
   reg_idx_t retire_rd_idx;

   // data bus
   logic [`ADDR_WIDTH-1:0] awaddr;
   logic awvalid;
   logic awready;
   logic [`DATA_WIDTH-1:0] wdata;
   logic [`STRB_WIDTH-1:0] wstrb;
   logic wvalid;
   logic wready;
   logic [1:0] bresp;
   logic bvalid;
   logic bready;
   logic [`ADDR_WIDTH-1:0] araddr;
   logic arvalid;
   logic arready;
   logic [`DATA_WIDTH-1:0] rdata;
   logic [1:0] rresp;
   logic rvalid;
   logic rready;

   assign retire_rd = retire_rd_idx;

   core_decode core_decode_inst (
      .clk(clk),
      .rst(rst),
      .instr(instr),
      .instr_valid(instr_valid),
      .instr_ready(instr_ready),
      .exe_ready(exe_ready),
      .rf_a_idx(rf_a_idx),
      .rf_b_idx(rf_b_idx),
      .rf_a(rf_a),
      .rf_b(rf_b),
      .wb_valid(wb_valid),
      .wb_rd(wb_rd),
      .dec_valid(dec_valid),
      .dec_op(dec_op),
      .dec_class(dec_class),
      .dec_rd(dec_rd),
      .dec_a(dec_a),
      .dec_b(dec_b),
      .dec_store_data(dec_store_data)
   );

   core_execute core_execute_inst (
      .clk(clk),
      .rst(rst),
      .dec_valid(dec_valid),
      .dec_op(dec_op),
      .dec_class(dec_class),
      .dec_rd(dec_rd),
      .dec_a(dec_a),
      .dec_b(dec_b),
      .dec_store_data(dec_store_data),
      .exe_ready(exe_ready),
      .res_valid(res_valid),
      .res_we(res_we),
      .res_rd(res_rd),
      .res_data(res_data),
      .m_axil_awaddr(awaddr),
      .m_axil_awvalid(awvalid),
      .m_axil_awready(awready),
      .m_axil_wdata(wdata),
      .m_axil_wstrb(wstrb),
      .m_axil_wvalid(wvalid),
      .m_axil_wready(wready),
      .m_axil_bresp(bresp),
      .m_axil_bvalid(bvalid),
      .m_axil_bready(bready),
      .m_axil_araddr(araddr),
      .m_axil_arvalid(arvalid),
      .m_axil_arready(arready),
      .m_axil_rdata(rdata),
      .m_axil_rresp(rresp),
      .m_axil_rvalid(rvalid),
      .m_axil_rready(rready)
   );

   core_result core_result_inst (
      .clk(clk),
      .rst(rst),
      .res_valid(res_valid),
      .res_we(res_we),
      .res_rd(res_rd),
      .res_data(res_data),
      .rf_a_idx(rf_a_idx),
      .rf_b_idx(rf_b_idx),
      .rf_a(rf_a),
      .rf_b(rf_b),
      .wb_valid(wb_valid),
      .wb_rd(wb_rd),
      .retire_valid(retire_valid),
      .retire_we(retire_we),
      .retire_rd(retire_rd_idx),
      .retire_data(retire_data)
   );

   axil_ram #(
      .DATA_WIDTH(`DATA_WIDTH),
      .ADDR_WIDTH(`ADDR_WIDTH),
      .STRB_WIDTH(`STRB_WIDTH)
   ) axil_ram_inst (
      .clk(clk),
      .rst(rst),
      .debug_addr(debug_addr),
      .debug_data(debug_data),
      .debug_wr_addr(debug_wr_addr),
      .debug_wr_data(debug_wr_data),
      .debug_wr_en(debug_wr_en),
      .s_axil_awaddr(awaddr),
      .s_axil_awvalid(awvalid),
      .s_axil_awready(awready),
      .s_axil_wdata(wdata),
      .s_axil_wstrb(wstrb),
      .s_axil_wvalid(wvalid),
      .s_axil_wready(wready),
      .s_axil_bresp(bresp),
      .s_axil_bvalid(bvalid),
      .s_axil_bready(bready),
      .s_axil_araddr(araddr),
      .s_axil_arvalid(arvalid),
      .s_axil_arready(arready),
      .s_axil_rdata(rdata),
      .s_axil_rresp(rresp),
      .s_axil_rvalid(rvalid),
      .s_axil_rready(rready)
   );

endmodule

// File: hdl/core_result.sv
`timescale 1ns/1ns
`include "mini_core_defs.svh"

module core_result (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    res_valid,
   input  logic                    res_we,
   input  mini_core_pkg::reg_idx_t res_rd,
   input  logic [`DATA_WIDTH-1:0]  res_data,
   input  mini_core_pkg::reg_idx_t rf_a_idx,
   input  mini_core_pkg::reg_idx_t rf_b_idx,
   output logic [`DATA_WIDTH-1:0]  rf_a,
   output logic [`DATA_WIDTH-1:0]  rf_b,
   output logic                    wb_valid,
   output mini_core_pkg::reg_idx_t wb_rd,
   output logic                    retire_valid,
   output logic                    retire_we,
   output mini_core_pkg::reg_idx_t retire_rd,
   output logic [`DATA_WIDTH-1:0]  retire_data
);

   logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

   // read ports, r0 hardwired to zero
   assign rf_a = (rf_a_idx == '0) ? '0 : regs[rf_a_idx];
   assign rf_b = (rf_b_idx == '0) ? '0 : regs[rf_b_idx];

   // write lands at the edge retire rises, so decode may clear busy now
   assign wb_valid = retire_valid && retire_we;
   assign wb_rd = retire_rd;

   always_ff @(posedge clk) begin
      if (rst) begin
         retire_valid <= 1'b0;
         for (int i = 0; i < `REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else begin
         retire_valid <= res_valid;
         if (res_valid && res_we && res_rd != '0) begin
            regs[res_rd] <= res_data;
         end
      end
      // retire report, one pulse per instruction
      retire_we <= res_we;
      retire_rd <= res_rd;
      retire_data <= res_data;
   end

endmodule

// File: hdl/core_execute.sv
`timescale 1ns/1ns
`include "mini_core_defs.svh"

module core_execute (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     dec_valid,
   input  mini_core_pkg::opcode_t   dec_op,
   input  mini_core_pkg::op_class_t dec_class,
   input  mini_core_pkg::reg_idx_t  dec_rd,
   input  logic [`DATA_WIDTH-1:0]   dec_a,
   input  logic [`DATA_WIDTH-1:0]   dec_b,
   input  logic [`DATA_WIDTH-1:0]   dec_store_data,
   output logic                     exe_ready,
   output logic                     res_valid,
   output logic                     res_we,
   output mini_core_pkg::reg_idx_t  res_rd,
   output logic [`DATA_WIDTH-1:0]   res_data,
   output logic [`ADDR_WIDTH-1:0]   m_axil_awaddr,
   output logic                     m_axil_awvalid,
   input  logic                     m_axil_awready,
   output logic [`DATA_WIDTH-1:0]   m_axil_wdata,
   output logic [`STRB_WIDTH-1:0]   m_axil_wstrb,
   output logic                     m_axil_wvalid,
   input  logic                     m_axil_wready,
   input  logic [1:0]               m_axil_bresp,
   input  logic                     m_axil_bvalid,
   output logic                     m_axil_bready,
   output logic [`ADDR_WIDTH-1:0]   m_axil_araddr,
   output logic                     m_axil_arvalid,
   input  logic                     m_axil_arready,
   input  logic [`DATA_WIDTH-1:0]   m_axil_rdata,
   input  logic [1:0]               m_axil_rresp,
   input  logic                     m_axil_rvalid,
   output logic                     m_axil_rready
);

   import mini_core_pkg::*;

   logic xfer;
   logic load_busy;
   logic store_busy;
   logic [`DATA_WIDTH-1:0] alu_out;
   logic [`ADDR_WIDTH-1:0] mem_addr;

   // one memory access at a time
   assign exe_ready = !load_busy && !store_busy;
   assign xfer = dec_valid && exe_ready;

   // responses are always taken at once
   assign m_axil_bready = 1'b1;
   assign m_axil_rready = 1'b1;

   // memory ops share the adder for the byte address
   always_comb begin
      case (dec_op)
         OP_ADD, OP_ADDI, OP_LUI, OP_LW, OP_SW, OP_SB: alu_out = dec_a + dec_b;
         OP_SUB: alu_out = dec_a - dec_b;
         OP_AND: alu_out = dec_a & dec_b;
         OP_OR: alu_out = dec_a | dec_b;
         OP_XOR: alu_out = dec_a ^ dec_b;
         default: alu_out = '0;
      endcase
   end

   assign mem_addr = alu_out[`ADDR_WIDTH-1:0];

   always_ff @(posedge clk) begin
      if (rst) begin
         res_valid <= 1'b0;
         load_busy <= 1'b0;
         store_busy <= 1'b0;
         m_axil_awvalid <= 1'b0;
         m_axil_wvalid <= 1'b0;
         m_axil_arvalid <= 1'b0;
      end else begin
         res_valid <= 1'b0;
         // drop each request once the RAM has it
         if (m_axil_awready) begin
            m_axil_awvalid <= 1'b0;
         end
         if (m_axil_wready) begin
            m_axil_wvalid <= 1'b0;
         end
         if (m_axil_arready) begin
            m_axil_arvalid <= 1'b0;
         end
         // memory op ends on its response
         if (store_busy && m_axil_bvalid) begin
            store_busy <= 1'b0;
            res_valid <= 1'b1;
         end
         if (load_busy && m_axil_rvalid) begin
            load_busy <= 1'b0;
            res_valid <= 1'b1;
         end
         if (xfer) begin
            case (dec_class)
               CLASS_LOAD: begin
                  m_axil_arvalid <= 1'b1;
                  load_busy <= 1'b1;
               end
               CLASS_STORE: begin
                  m_axil_awvalid <= 1'b1;
                  m_axil_wvalid <= 1'b1;
                  store_busy <= 1'b1;
               end
               // ALU ops and no-ops report next cycle
               default: res_valid <= 1'b1;
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (xfer) begin
         res_rd <= dec_rd;
         res_we <= (dec_class == CLASS_ALU || dec_class == CLASS_LOAD) && dec_rd != '0;
         res_data <= alu_out;
         m_axil_awaddr <= mem_addr;
         m_axil_araddr <= mem_addr;
         // SB replicates the byte, strobe picks the lane
         if (dec_op == OP_SB) begin
            m_axil_wdata <= {`STRB_WIDTH{dec_store_data[7:0]}};
            m_axil_wstrb <= `STRB_WIDTH'(1) << mem_addr[1:0];
         end else begin
            m_axil_wdata <= dec_store_data;
            m_axil_wstrb <= '1;
         end
      end
      // load data replaces the address, written back only on OKAY
      if (load_busy && m_axil_rvalid) begin
         res_data <= m_axil_rdata;
         res_we <= res_we && m_axil_rresp == 2'b00;
      end
      // stores report the write response code
      if (store_busy && m_axil_bvalid) begin
         res_data <= {{(`DATA_WIDTH-2){1'b0}}, m_axil_bresp};
      end
   end

endmodule

// File: hdl/core_decode.sv
`timescale 1ns/1ns
`include "mini_core_defs.svh"

module core_decode (
   input  logic                     clk,
   input  logic                     rst,
   input  logic [`DATA_WIDTH-1:0]   instr,
   input  logic                     instr_valid,
   output logic                     instr_ready,
   input  logic                     exe_ready,
   output mini_core_pkg::reg_idx_t  rf_a_idx,
   output mini_core_pkg::reg_idx_t  rf_b_idx,
   input  logic [`DATA_WIDTH-1:0]   rf_a,
   input  logic [`DATA_WIDTH-1:0]   rf_b,
   input  logic                     wb_valid,
   input  mini_core_pkg::reg_idx_t  wb_rd,
   output logic                     dec_valid,
   output mini_core_pkg::opcode_t   dec_op,
   output mini_core_pkg::op_class_t dec_class,
   output mini_core_pkg::reg_idx_t  dec_rd,
   output logic [`DATA_WIDTH-1:0]   dec_a,
   output logic [`DATA_WIDTH-1:0]   dec_b,
   output logic [`DATA_WIDTH-1:0]   dec_store_data
);

   import mini_core_pkg::*;

   logic [3:0] op_field;
   reg_idx_t rd;
   logic [15:0] imm;
   opcode_t op_n;
   op_class_t class_n;
   logic [`DATA_WIDTH-1:0] a_sel;
   logic [`DATA_WIDTH-1:0] b_sel;
   logic use_a;
   logic use_b;
   logic writes_rd;
   logic [`REG_COUNT-1:0] busy;
   logic [`REG_COUNT-1:0] busy_now;
   logic [`REG_COUNT-1:0] wb_mask;
   logic [`REG_COUNT-1:0] set_mask;
   logic active;
   logic hazard;
   logic hold;
   logic accept;

   // field split
   assign op_field = instr[31:28];
   assign rd = instr[27:24];
   assign rf_a_idx = instr[23:20];
   assign rf_b_idx = instr[19:16];
   assign imm = instr[15:0];

   always_comb begin
      op_n = OP_NOP;
      class_n = CLASS_NONE;
      use_a = 1'b0;
      use_b = 1'b0;
      a_sel = rf_a;
      // register operand unless the opcode wants the immediate
      b_sel = rf_b;
      case (op_field)
         OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
            op_n = opcode_t'(op_field);
            class_n = CLASS_ALU;
            use_a = 1'b1;
            use_b = 1'b1;
         end
         OP_ADDI: begin
            op_n = OP_ADDI;
            class_n = CLASS_ALU;
            use_a = 1'b1;
            b_sel = {{16{imm[15]}}, imm};
         end
         OP_LUI: begin
            // execute adds, so zero the A side
            op_n = OP_LUI;
            class_n = CLASS_ALU;
            a_sel = '0;
            b_sel = {imm, 16'h0000};
         end
         OP_LW: begin
            op_n = OP_LW;
            class_n = CLASS_LOAD;
            use_a = 1'b1;
            b_sel = {{16{imm[15]}}, imm};
         end
         OP_SW, OP_SB: begin
            // rs2 rides along as store data
            op_n = opcode_t'(op_field);
            class_n = CLASS_STORE;
            use_a = 1'b1;
            use_b = 1'b1;
            b_sel = {{16{imm[15]}}, imm};
         end
         default: begin
            // unused encodings fall through as a no-op
         end
      endcase
   end

   // r0 never goes busy
   assign writes_rd = (class_n == CLASS_ALU || class_n == CLASS_LOAD) && rd != '0;

   // a register written back this cycle is already readable
   assign wb_mask = wb_valid ? (`REG_COUNT'(1) << wb_rd) : '0;
   assign busy_now = busy & ~wb_mask;
   assign set_mask = (accept && writes_rd) ? (`REG_COUNT'(1) << rd) : '0;

   // sources wait on busy, rd too so two writes to one register never overlap
   assign hazard = (use_a && busy_now[rf_a_idx]) || (use_b && busy_now[rf_b_idx]) ||
                   (writes_rd && busy_now[rd]);

   // output bundle stuck behind execute
   assign hold = dec_valid && !exe_ready;
   assign instr_ready = active && !hold && !hazard;
   assign accept = instr_valid && instr_ready;

   always_ff @(posedge clk) begin
      if (rst) begin
         active <= 1'b0;
         dec_valid <= 1'b0;
         busy <= '0;
      end else begin
         active <= 1'b1;
         busy <= busy_now | set_mask;
         if (accept) begin
            dec_valid <= 1'b1;
         end else if (exe_ready) begin
            dec_valid <= 1'b0;
         end
      end
      if (accept) begin
         dec_op <= op_n;
         dec_class <= class_n;
         dec_rd <= rd;
         dec_a <= a_sel;
         dec_b <= b_sel;
         dec_store_data <= rf_b;
      end
   end

endmodule

// File: hdl/axil_ram.sv
`timescale 1ns/1ns
`include "mini_core_defs.svh"

module axil_ram #(
   parameter int DATA_WIDTH = `DATA_WIDTH,
   parameter int ADDR_WIDTH = `ADDR_WIDTH,
   parameter int STRB_WIDTH = `STRB_WIDTH
) (
   input  logic                  clk,
   input  logic                  rst,

   // host side debug access, word indexed
   input  logic [ADDR_WIDTH-1:0] debug_addr,
   output logic [DATA_WIDTH-1:0] debug_data,
   input  logic [ADDR_WIDTH-1:0] debug_wr_addr,
   input  logic [DATA_WIDTH-1:0] debug_wr_data,
   input  logic                  debug_wr_en,

   // write address, write data and write response
   input  logic [ADDR_WIDTH-1:0] s_axil_awaddr,
   input  logic                  s_axil_awvalid,
   output logic                  s_axil_awready,
   input  logic [DATA_WIDTH-1:0] s_axil_wdata,
   input  logic [STRB_WIDTH-1:0] s_axil_wstrb,
   input  logic                  s_axil_wvalid,
   output logic                  s_axil_wready,
   output logic [1:0]            s_axil_bresp,
   output logic                  s_axil_bvalid,
   input  logic                  s_axil_bready,

   // read address and read data
   input  logic [ADDR_WIDTH-1:0] s_axil_araddr,
   input  logic                  s_axil_arvalid,
   output logic                  s_axil_arready,
   output logic [DATA_WIDTH-1:0] s_axil_rdata,
   output logic [1:0]            s_axil_rresp,
   output logic                  s_axil_rvalid,
   input  logic                  s_axil_rready
);

   localparam int VALID_ADDR_WIDTH = ADDR_WIDTH - $clog2(STRB_WIDTH);
   localparam int WORD_SIZE = DATA_WIDTH / STRB_WIDTH;

   logic [DATA_WIDTH-1:0] mem [2**VALID_ADDR_WIDTH];
   logic [VALID_ADDR_WIDTH-1:0] aw_word;
   logic [VALID_ADDR_WIDTH-1:0] ar_word;
   logic mem_wr_en;
   logic mem_rd_en;

   // drop the byte offset bits
   assign aw_word = s_axil_awaddr[ADDR_WIDTH-1:ADDR_WIDTH-VALID_ADDR_WIDTH];
   assign ar_word = s_axil_araddr[ADDR_WIDTH-1:ADDR_WIDTH-VALID_ADDR_WIDTH];

   // combinational debug read
   assign debug_data = mem[debug_addr[VALID_ADDR_WIDTH-1:0]];

   // always OKAY
   assign s_axil_bresp = 2'b00;
   assign s_axil_rresp = 2'b00;

   // take a write once both channels are up and the last response is gone
   // awready high for one cycle blocks a second take of the same request
   assign mem_wr_en = s_axil_awvalid && s_axil_wvalid &&
                      (!s_axil_bvalid || s_axil_bready) &&
                      !s_axil_awready && !s_axil_wready;

   // same idea on the read side
   assign mem_rd_en = s_axil_arvalid && (!s_axil_rvalid || s_axil_rready) &&
                      !s_axil_arready;

   always_ff @(posedge clk) begin
      if (rst) begin
         s_axil_awready <= 1'b0;
         s_axil_wready <= 1'b0;
         s_axil_bvalid <= 1'b0;
         s_axil_arready <= 1'b0;
         s_axil_rvalid <= 1'b0;
      end else begin
         s_axil_awready <= mem_wr_en;
         s_axil_wready <= mem_wr_en;
         s_axil_arready <= mem_rd_en;
         // response held until the master takes it
         if (mem_wr_en) begin
            s_axil_bvalid <= 1'b1;
         end else if (s_axil_bready) begin
            s_axil_bvalid <= 1'b0;
         end
         if (mem_rd_en) begin
            s_axil_rvalid <= 1'b1;
         end else if (s_axil_rready) begin
            s_axil_rvalid <= 1'b0;
         end
      end
      if (mem_rd_en) begin
         s_axil_rdata <= mem[ar_word];
      end
   end

   // storage, debug write first so a bus write to the same word wins
   always_ff @(posedge clk) begin
      if (debug_wr_en) begin
         mem[debug_wr_addr[VALID_ADDR_WIDTH-1:0]] <= debug_wr_data;
      end
      for (int i = 0; i < STRB_WIDTH; i++) begin
         if (mem_wr_en && s_axil_wstrb[i]) begin
            mem[aw_word][WORD_SIZE*i +: WORD_SIZE] <= s_axil_wdata[WORD_SIZE*i +: WORD_SIZE];
         end
      end
   end

endmodule

// File: hdl/mini_core_pkg.sv
`include "mini_core_defs.svh"

package mini_core_pkg;

   // opcode field, instruction bits 31..28
   // encodings 11..15 are unused and retire as no-ops
   typedef enum logic [3:0] {
      OP_NOP  = 4'd0,
      OP_ADD  = 4'd1,
      OP_SUB  = 4'd2,
      OP_AND  = 4'd3,
      OP_OR   = 4'd4,
      OP_XOR  = 4'd5,
      OP_ADDI = 4'd6,
      OP_LUI  = 4'd7,
      OP_LW   = 4'd8,
      OP_SW   = 4'd9,
      OP_SB   = 4'd10
   } opcode_t;

   // coarse class, picks the execute path
   typedef enum logic [1:0] {
      CLASS_ALU   = 2'd0,
      CLASS_LOAD  = 2'd1,
      CLASS_STORE = 2'd2,
      CLASS_NONE  = 2'd3
   } op_class_t;

   typedef logic [`REG_IDX_WIDTH-1:0] reg_idx_t;

endpackage

// File: hdl/mini_core_defs.svh
`ifndef MINI_CORE_DEFS_SVH
`define MINI_CORE_DEFS_SVH

// data path and instruction word width
`define DATA_WIDTH 32

// byte address into the data RAM, 1024 words
`define ADDR_WIDTH 12

// byte lanes per data word
`define STRB_WIDTH 4

// register file size and index width
`define REG_COUNT 16
`define REG_IDX_WIDTH 4

`endif
